// ==== axil_mem_subsystem.f ====
+incdir+include
rtl/axil_mem_pkg.sv
rtl/mem_msg_fifo.sv
rtl/mem_scratchpad.sv
rtl/axil_mem_client_bridge.sv
rtl/axil_mem_subsystem.sv
verification/axil_mem_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: axil_mem_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/axil_mem_pkg.sv
      - rtl/mem_msg_fifo.sv
      - rtl/mem_scratchpad.sv
      - rtl/axil_mem_client_bridge.sv
      - rtl/axil_mem_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/axil_mem_subsystem_tb.sv

// ==== verification/axil_mem_subsystem_tb.sv ====
`timescale 1ns/1ns
`include "axil_mem_defs.svh"

module axil_mem_subsystem_tb;

  typedef enum logic [1:0] {e_op_read, e_op_write, e_op_both} op_e;

  // One stimulus row, expected response code included
  typedef struct packed
  {
    op_e                         op;
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    logic [`AXIL_DATA_WIDTH-1:0] wdata;
    logic [`AXIL_STRB_WIDTH-1:0] wstrb;
    logic                        exp_err;
    logic [3:0]                  bstall;
    logic [3:0]                  rstall;
  } stim_row_s;

  logic                        clk_i;
  logic                        reset_i;
  logic [`AXIL_ADDR_WIDTH-1:0] awaddr, araddr;
  logic [2:0]                  awprot, arprot;
  logic                        awvalid, awready, arvalid, arready;
  logic [`AXIL_DATA_WIDTH-1:0] wdata, rdata;
  logic [`AXIL_STRB_WIDTH-1:0] wstrb;
  logic                        wvalid, wready;
  logic                        bvalid, bready, rvalid, rready;
  axil_mem_pkg::axil_resp_e    bresp, rresp;

  stim_row_s                   rows [$];
  logic [`AXIL_DATA_WIDTH-1:0] ref_mem [`SCRATCH_WORDS];
  integer                      seed = 67514;
  int                          cycle_count = 0;

  axil_mem_subsystem dut
    (.clk_i              (clk_i)
     , .reset_i          (reset_i)
     , .s_axil_awaddr_i  (awaddr)
     , .s_axil_awprot_i  (awprot)
     , .s_axil_awvalid_i (awvalid)
     , .s_axil_awready_o (awready)
     , .s_axil_wdata_i   (wdata)
     , .s_axil_wstrb_i   (wstrb)
     , .s_axil_wvalid_i  (wvalid)
     , .s_axil_wready_o  (wready)
     , .s_axil_bresp_o   (bresp)
     , .s_axil_bvalid_o  (bvalid)
     , .s_axil_bready_i  (bready)
     , .s_axil_araddr_i  (araddr)
     , .s_axil_arprot_i  (arprot)
     , .s_axil_arvalid_i (arvalid)
     , .s_axil_arready_o (arready)
     , .s_axil_rdata_o   (rdata)
     , .s_axil_rresp_o   (rresp)
     , .s_axil_rvalid_o  (rvalid)
     , .s_axil_rready_i  (rready)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Worst case budget of twenty cycles per row
  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= rows.size() * 20 + 100)
    begin
      $display("Timeout: the table did not finish within %0d cycles", cycle_count);
      $display("ERRORS FOUND");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic stop_on_mismatch(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected)
      stop_on_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
  endtask

  task automatic check_resp(input axil_mem_pkg::axil_resp_e actual,
                            input axil_mem_pkg::axil_resp_e expected, input string what);
    if (actual !== expected)
      stop_on_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
  endtask

  task automatic check_rdata(input logic [`AXIL_DATA_WIDTH-1:0] actual,
                             input logic [`AXIL_DATA_WIDTH-1:0] expected);
    if (actual !== expected)
      stop_on_mismatch($sformatf("rdata is %h, expected %h", actual, expected));
  endtask

  task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input logic exp_err);
    stim_row_s row;
    row.op      = op;
    row.addr    = addr;
    row.wdata   = data;
    row.wstrb   = strb;
    row.exp_err = exp_err;
    row.bstall  = $unsigned($random(seed)) % 9;
    row.rstall  = $unsigned($random(seed)) % 9;
    rows.push_back(row);
  endtask

  task automatic load_table();
    add_row(e_op_write, 32'h0000_0000, 32'h1122_3344, 4'hF, 1'b0);
    add_row(e_op_read,  32'h0000_0000, 32'h0,         4'h0, 1'b0);
    add_row(e_op_write, 32'h0000_0004, 32'hAABB_CCDD, 4'hF, 1'b0);
    add_row(e_op_write, 32'h0000_0004, 32'h0000_0077, 4'h1, 1'b0);
    add_row(e_op_read,  32'h0000_0004, 32'h0,         4'h0, 1'b0);
    // Byte offset in the address is ignored
    add_row(e_op_write, 32'h0000_0006, 32'h1234_5566, 4'h3, 1'b0);
    add_row(e_op_read,  32'h0000_0007, 32'h0,         4'h0, 1'b0);
    add_row(e_op_write, 32'h0000_00FC, 32'hDEAD_BEEF, 4'hF, 1'b0);
    add_row(e_op_read,  32'h0000_00FC, 32'h0,         4'h0, 1'b0);
    add_row(e_op_write, 32'h0000_0100, 32'hCAFE_F00D, 4'hF, 1'b1);
    add_row(e_op_read,  32'h0000_0100, 32'h0,         4'h0, 1'b1);
    add_row(e_op_write, 32'h8000_0040, 32'h0BAD_F00D, 4'hF, 1'b1);
    add_row(e_op_read,  32'h8000_0040, 32'h0,         4'h0, 1'b1);
    // Out-of-range writes must not alias onto low words
    add_row(e_op_read,  32'h0000_0000, 32'h0,         4'h0, 1'b0);
    add_row(e_op_read,  32'h0000_00FC, 32'h0,         4'h0, 1'b0);
    add_row(e_op_both,  32'h0000_0000, 32'h5566_7788, 4'hF, 1'b0);
    add_row(e_op_read,  32'h0000_0000, 32'h0,         4'h0, 1'b0);
    add_row(e_op_write, 32'h0000_0084, 32'h0102_0304, 4'hF, 1'b0);
    add_row(e_op_both,  32'h0000_0084, 32'h0000_00EE, 4'h1, 1'b0);
    add_row(e_op_read,  32'h0000_0084, 32'h0,         4'h0, 1'b0);
    add_row(e_op_both,  32'h0000_0300, 32'h0000_0001, 4'hF, 1'b1);
    add_row(e_op_read,  32'h0000_0004, 32'h0,         4'h0, 1'b0);
  endtask

  // Reference model, zero data outside the scratchpad
  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    if (addr < `SCRATCH_WORDS * 4)
      return ref_mem[addr >> 2];
    return '0;
  endfunction

  task automatic ref_write(input stim_row_s row);
    logic [31:0] word;
    if (row.addr < `SCRATCH_WORDS * 4)
    begin
      word = ref_mem[row.addr >> 2];
      for (int b = 0; b < `AXIL_STRB_WIDTH; b++)
      begin
        if (row.wstrb[b])
          word[8*b +: 8] = row.wdata[8*b +: 8];
      end
      ref_mem[row.addr >> 2] = word;
    end
  endtask

  function automatic logic resp_valid(input logic is_read);
    return is_read ? rvalid : bvalid;
  endfunction

  // Nothing may be accepted while a response is pending
  task automatic check_ports_busy(input logic is_read);
    check_flag(arready, 1'b0, "arready with a response outstanding");
    check_flag(awready, 1'b0, "awready with a response outstanding");
    check_flag(wready, 1'b0, "wready with a response outstanding");
    check_flag(is_read ? bvalid : rvalid, 1'b0, "valid on the other response channel");
  endtask

  task automatic check_payload(input logic is_read, input logic [31:0] exp_data,
                               input axil_mem_pkg::axil_resp_e exp_resp);
    if (is_read)
    begin
      check_rdata(rdata, exp_data);
      check_resp(rresp, exp_resp, "rresp");
    end
    else
      check_resp(bresp, exp_resp, "bresp");
  endtask

  task automatic await_accept(input logic is_read);
    do
    begin
      @(negedge clk_i);
    end
    while (!(is_read ? arready : (awready && wready)));
  endtask

  task automatic finish_response(input logic is_read, input logic [31:0] exp_data,
                                 input axil_mem_pkg::axil_resp_e exp_resp, input int stall);
    do
    begin
      @(negedge clk_i);
      check_ports_busy(is_read);
    end
    while (!resp_valid(is_read));

    // Held response must stay valid and unchanged
    for (int i = 0; i <= stall; i++)
    begin
      if (i > 0)
        @(negedge clk_i);
      check_flag(resp_valid(is_read), 1'b1, "response valid during stall");
      check_ports_busy(is_read);
      check_payload(is_read, exp_data, exp_resp);
    end

    @(posedge clk_i);
    #1;
    if (is_read)
      rready = 1'b1;
    else
      bready = 1'b1;
    @(negedge clk_i);
    check_flag(resp_valid(is_read), 1'b1, "response valid at handshake");
    check_payload(is_read, exp_data, exp_resp);
    @(posedge clk_i);
    #1;
    rready = 1'b0;
    bready = 1'b0;
  endtask

  task automatic apply_row(input stim_row_s row);
    logic [31:0]              exp_data;
    axil_mem_pkg::axil_resp_e exp_resp;
    exp_data = ref_read(row.addr);
    exp_resp = row.exp_err ? axil_mem_pkg::e_axil_resp_slverr
                           : axil_mem_pkg::e_axil_resp_okay;
    araddr = row.addr;
    awaddr = row.addr;
    wdata  = row.wdata;
    wstrb  = row.wstrb;

    case (row.op)
      e_op_read:
      begin
        arvalid = 1'b1;
        await_accept(1'b1);
        @(posedge clk_i);
        #1;
        arvalid = 1'b0;
        finish_response(1'b1, exp_data, exp_resp, row.rstall);
      end

      e_op_write:
      begin
        awvalid = 1'b1;
        wvalid  = 1'b1;
        await_accept(1'b0);
        @(posedge clk_i);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        finish_response(1'b0, '0, exp_resp, row.bstall);
        ref_write(row);
      end

      default:
      begin
        // Read wins and returns the value from before the write
        arvalid = 1'b1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk_i);
        check_flag(arready, 1'b1, "arready with AR and AW+W valid");
        check_flag(awready, 1'b0, "awready with AR and AW+W valid");
        check_flag(wready, 1'b0, "wready with AR and AW+W valid");
        @(posedge clk_i);
        #1;
        arvalid = 1'b0;
        finish_response(1'b1, exp_data, exp_resp, row.rstall);
        await_accept(1'b0);
        @(posedge clk_i);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        finish_response(1'b0, '0, exp_resp, row.bstall);
        ref_write(row);
      end
    endcase
  endtask

  initial
  begin
    reset_i = 1'b1;
    awaddr  = '0;
    awprot  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arprot  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    load_table();

    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    @(negedge clk_i);
    check_flag(bvalid, 1'b0, "bvalid after reset");
    check_flag(rvalid, 1'b0, "rvalid after reset");
    check_flag(arready, 1'b1, "arready after reset");
    check_flag(awready, 1'b1, "awready after reset");
    check_flag(wready, 1'b1, "wready after reset");
    @(posedge clk_i);
    #1;

    foreach (rows[i])
      apply_row(rows[i]);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== rtl/axil_mem_subsystem.sv ====
`timescale 1ns/1ns
`include "axil_mem_defs.svh"

module axil_mem_subsystem
  (input                                 clk_i
   , input                               reset_i

   , input [`AXIL_ADDR_WIDTH-1:0]        s_axil_awaddr_i
   , input [2:0]                         s_axil_awprot_i
   , input                               s_axil_awvalid_i
   , output logic                        s_axil_awready_o

   , input [`AXIL_DATA_WIDTH-1:0]        s_axil_wdata_i
   , input [`AXIL_STRB_WIDTH-1:0]        s_axil_wstrb_i
   , input                               s_axil_wvalid_i
   , output logic                        s_axil_wready_o

   , output axil_mem_pkg::axil_resp_e    s_axil_bresp_o
   , output logic                        s_axil_bvalid_o
   , input                               s_axil_bready_i

   , input [`AXIL_ADDR_WIDTH-1:0]        s_axil_araddr_i
   , input [2:0]                         s_axil_arprot_i
   , input                               s_axil_arvalid_i
   , output logic                        s_axil_arready_o

   , output logic [`AXIL_DATA_WIDTH-1:0] s_axil_rdata_o
   , output axil_mem_pkg::axil_resp_e    s_axil_rresp_o
   , output logic                        s_axil_rvalid_o
   , input                               s_axil_rready_i
  );

  // Command path
  axil_mem_pkg::mem_cmd_s  bridge_cmd, fifo_cmd;
  logic                    bridge_cmd_v, bridge_cmd_yumi;
  logic                    fifo_cmd_v, pad_cmd_yumi;

  // Response path
  axil_mem_pkg::mem_resp_s pad_resp, fifo_resp;
  logic                    pad_resp_v, resp_fifo_ready;
  logic                    fifo_resp_v, bridge_resp_ready;

  axil_mem_client_bridge bridge
    (.clk_i            (clk_i)
     , .reset_i        (reset_i)
     , .s_axil_awaddr_i  (s_axil_awaddr_i)
     , .s_axil_awprot_i  (s_axil_awprot_i)
     , .s_axil_awvalid_i (s_axil_awvalid_i)
     , .s_axil_awready_o (s_axil_awready_o)
     , .s_axil_wdata_i   (s_axil_wdata_i)
     , .s_axil_wstrb_i   (s_axil_wstrb_i)
     , .s_axil_wvalid_i  (s_axil_wvalid_i)
     , .s_axil_wready_o  (s_axil_wready_o)
     , .s_axil_bresp_o   (s_axil_bresp_o)
     , .s_axil_bvalid_o  (s_axil_bvalid_o)
     , .s_axil_bready_i  (s_axil_bready_i)
     , .s_axil_araddr_i  (s_axil_araddr_i)
     , .s_axil_arprot_i  (s_axil_arprot_i)
     , .s_axil_arvalid_i (s_axil_arvalid_i)
     , .s_axil_arready_o (s_axil_arready_o)
     , .s_axil_rdata_o   (s_axil_rdata_o)
     , .s_axil_rresp_o   (s_axil_rresp_o)
     , .s_axil_rvalid_o  (s_axil_rvalid_o)
     , .s_axil_rready_i  (s_axil_rready_i)
     , .mem_cmd_o        (bridge_cmd)
     , .mem_cmd_v_o      (bridge_cmd_v)
     , .mem_cmd_yumi_i   (bridge_cmd_yumi)
     , .mem_resp_i       (fifo_resp)
     , .mem_resp_v_i     (fifo_resp_v)
     , .mem_resp_ready_o (bridge_resp_ready)
    );

  // FIFO ready doubles as the bridge's yumi
  mem_msg_fifo #(.item_t(axil_mem_pkg::mem_cmd_s)) cmd_fifo
    (.clk_i     (clk_i)
     , .reset_i (reset_i)
     , .data_i  (bridge_cmd)
     , .v_i     (bridge_cmd_v)
     , .ready_o (bridge_cmd_yumi)
     , .data_o  (fifo_cmd)
     , .v_o     (fifo_cmd_v)
     , .yumi_i  (pad_cmd_yumi)
    );

  mem_scratchpad scratchpad
    (.clk_i              (clk_i)
     , .reset_i          (reset_i)
     , .mem_cmd_i        (fifo_cmd)
     , .mem_cmd_v_i      (fifo_cmd_v)
     , .mem_cmd_yumi_o   (pad_cmd_yumi)
     , .mem_resp_o       (pad_resp)
     , .mem_resp_v_o     (pad_resp_v)
     , .mem_resp_ready_i (resp_fifo_ready)
    );

  mem_msg_fifo #(.item_t(axil_mem_pkg::mem_resp_s)) resp_fifo
    (.clk_i     (clk_i)
     , .reset_i (reset_i)
     , .data_i  (pad_resp)
     , .v_i     (pad_resp_v)
     , .ready_o (resp_fifo_ready)
     , .data_o  (fifo_resp)
     , .v_o     (fifo_resp_v)
     , .yumi_i  (fifo_resp_v & bridge_resp_ready)
    );

endmodule

// ==== rtl/axil_mem_client_bridge.sv ====
`timescale 1ns/1ns
`include "axil_mem_defs.svh"

module axil_mem_client_bridge
  (input                                clk_i
   , input                              reset_i

   // Write address channel
   , input [`AXIL_ADDR_WIDTH-1:0]       s_axil_awaddr_i
   , input [2:0]                        s_axil_awprot_i
   , input                              s_axil_awvalid_i
   , output logic                       s_axil_awready_o

   // Write data channel
   , input [`AXIL_DATA_WIDTH-1:0]       s_axil_wdata_i
   , input [`AXIL_STRB_WIDTH-1:0]       s_axil_wstrb_i
   , input                              s_axil_wvalid_i
   , output logic                       s_axil_wready_o

   // Write response channel
   , output axil_mem_pkg::axil_resp_e   s_axil_bresp_o
   , output logic                       s_axil_bvalid_o
   , input                              s_axil_bready_i

   // Read address channel
   , input [`AXIL_ADDR_WIDTH-1:0]       s_axil_araddr_i
   , input [2:0]                        s_axil_arprot_i
   , input                              s_axil_arvalid_i
   , output logic                       s_axil_arready_o

   // Read data channel
   , output logic [`AXIL_DATA_WIDTH-1:0] s_axil_rdata_o
   , output axil_mem_pkg::axil_resp_e   s_axil_rresp_o
   , output logic                       s_axil_rvalid_o
   , input                              s_axil_rready_i

   // Memory side
   , output axil_mem_pkg::mem_cmd_s     mem_cmd_o
   , output logic                       mem_cmd_v_o
   , input                              mem_cmd_yumi_i

   , input axil_mem_pkg::mem_resp_s     mem_resp_i
   , input                              mem_resp_v_i
   , output logic                       mem_resp_ready_o
  );

  // Protection bits are accepted on AR and AW but play no role here

  typedef enum logic [1:0] {e_wait, e_write_resp, e_read_resp} state_e;

  state_e state_r, state_n;
  axil_mem_pkg::mem_size_e wr_size;
  logic cmd_taken;

  // Strobe to access size
  always_comb
  begin
    case (s_axil_wstrb_i)
      4'h1:    wr_size = axil_mem_pkg::e_mem_size_1;
      4'h3:    wr_size = axil_mem_pkg::e_mem_size_2;
      default: wr_size = axil_mem_pkg::e_mem_size_4;
    endcase
  end

  assign cmd_taken = mem_cmd_v_o & mem_cmd_yumi_i;

  always_comb
  begin
    mem_cmd_o          = '0;
    mem_cmd_o.size     = axil_mem_pkg::e_mem_size_4;
    mem_cmd_v_o        = 1'b0;
    mem_resp_ready_o   = 1'b0;
    s_axil_arready_o   = 1'b0;
    s_axil_awready_o   = 1'b0;
    s_axil_wready_o    = 1'b0;
    s_axil_bvalid_o    = 1'b0;
    s_axil_bresp_o     = axil_mem_pkg::e_axil_resp_okay;
    s_axil_rvalid_o    = 1'b0;
    s_axil_rresp_o     = axil_mem_pkg::e_axil_resp_okay;
    s_axil_rdata_o     = '0;
    state_n            = state_r;

    case (state_r)
      e_wait:
      begin
        // Ready when idle
        // A pending request is acknowledged only as its command goes out
        s_axil_arready_o = ~s_axil_arvalid_i | cmd_taken;
        s_axil_awready_o = ~s_axil_arvalid_i & (~s_axil_awvalid_i | cmd_taken);
        s_axil_wready_o  = ~s_axil_arvalid_i & (~s_axil_wvalid_i | cmd_taken);

        if (s_axil_arvalid_i)
        begin
          mem_cmd_o.msg_type = axil_mem_pkg::e_mem_uc_rd;
          mem_cmd_o.addr     = s_axil_araddr_i;
          mem_cmd_v_o        = 1'b1;
          state_n = cmd_taken ? e_read_resp : e_wait;
        end
        else if (s_axil_awvalid_i & s_axil_wvalid_i)
        begin
          mem_cmd_o.msg_type = axil_mem_pkg::e_mem_uc_wr;
          mem_cmd_o.size     = wr_size;
          mem_cmd_o.addr     = s_axil_awaddr_i;
          mem_cmd_o.data     = s_axil_wdata_i;
          mem_cmd_v_o        = 1'b1;
          state_n = cmd_taken ? e_write_resp : e_wait;
        end
      end

      e_write_resp:
      begin
        s_axil_bvalid_o  = mem_resp_v_i;
        s_axil_bresp_o   = mem_resp_i.err ? axil_mem_pkg::e_axil_resp_slverr
                                          : axil_mem_pkg::e_axil_resp_okay;
        mem_resp_ready_o = s_axil_bready_i;
        if (mem_resp_v_i & s_axil_bready_i)
          state_n = e_wait;
      end

      e_read_resp:
      begin
        s_axil_rvalid_o  = mem_resp_v_i;
        s_axil_rdata_o   = mem_resp_i.data;
        s_axil_rresp_o   = mem_resp_i.err ? axil_mem_pkg::e_axil_resp_slverr
                                          : axil_mem_pkg::e_axil_resp_okay;
        mem_resp_ready_o = s_axil_rready_i;
        if (mem_resp_v_i & s_axil_rready_i)
          state_n = e_wait;
      end

      default: state_n = e_wait;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_wait;
    else
      state_r <= state_n;
  end

  // Only byte, halfword and word strobes are supported
  a_strb_supported: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == e_wait && s_axil_wvalid_i) |-> (s_axil_wstrb_i inside {4'h1, 4'h3, 4'hF}))
    else $error("unsupported write strobe %b", s_axil_wstrb_i);

  // A B beat must carry the answer to a write command
  a_bvalid_write: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_bvalid_o |-> (mem_resp_i.msg_type == axil_mem_pkg::e_mem_uc_wr))
    else $error("bvalid with a read response");

endmodule

// ==== rtl/mem_scratchpad.sv ====
`timescale 1ns/1ns
`include "axil_mem_defs.svh"

module mem_scratchpad
  (input                             clk_i
   , input                           reset_i

   , input axil_mem_pkg::mem_cmd_s   mem_cmd_i
   , input                           mem_cmd_v_i
   , output logic                    mem_cmd_yumi_o

   , output axil_mem_pkg::mem_resp_s mem_resp_o
   , output logic                    mem_resp_v_o
   , input                           mem_resp_ready_i
  );

  localparam int idx_width_lp = $clog2(`SCRATCH_WORDS);

  logic [`AXIL_DATA_WIDTH-1:0] mem_r [`SCRATCH_WORDS];
  logic [idx_width_lp-1:0]     idx;
  logic                        in_range;
  logic                        is_write;
  logic [`AXIL_STRB_WIDTH-1:0] lane_mask;
  axil_mem_pkg::mem_resp_s     resp_r;
  logic                        resp_v_r;

  // Word select from bits 7:2, byte offset ignored
  assign idx      = mem_cmd_i.addr[idx_width_lp+1:2];
  assign in_range = (mem_cmd_i.addr[`AXIL_ADDR_WIDTH-1:idx_width_lp+2] == '0);
  assign is_write = (mem_cmd_i.msg_type == axil_mem_pkg::e_mem_uc_wr);

  always_comb
  begin
    case (mem_cmd_i.size)
      axil_mem_pkg::e_mem_size_1: lane_mask = 4'b0001;
      axil_mem_pkg::e_mem_size_2: lane_mask = 4'b0011;
      default:                    lane_mask = 4'b1111;
    endcase
  end

  // Take a command when the output register is free or draining
  assign mem_cmd_yumi_o = mem_cmd_v_i & (~resp_v_r | mem_resp_ready_i);

  always_ff @(posedge clk_i)
  begin
    if (mem_cmd_yumi_o && is_write && in_range)
    begin
      for (int b = 0; b < `AXIL_STRB_WIDTH; b++)
      begin
        if (lane_mask[b])
          mem_r[idx][8*b +: 8] <= mem_cmd_i.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mem_cmd_yumi_o)
    begin
      resp_r.msg_type <= mem_cmd_i.msg_type;
      resp_r.err      <= ~in_range;
      resp_r.data     <= (!is_write && in_range) ? mem_r[idx] : '0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (mem_cmd_yumi_o)
      resp_v_r <= 1'b1;
    else if (mem_resp_ready_i)
      resp_v_r <= 1'b0;
  end

  assign mem_resp_o   = resp_r;
  assign mem_resp_v_o = resp_v_r;

  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_resp_v_o && !mem_resp_ready_i) |=> (mem_resp_v_o && $stable(mem_resp_o)))
    else $error("response changed while stalled");

endmodule

// ==== rtl/mem_msg_fifo.sv ====
`timescale 1ns/1ns
`include "axil_mem_defs.svh"

module mem_msg_fifo
  #(parameter type item_t = logic)
  (input           clk_i
   , input         reset_i

   , input item_t  data_i
   , input         v_i
   , output logic  ready_o

   , output item_t data_o
   , output logic  v_o
   , input         yumi_i
  );

  item_t      mem_r [2];
  logic       wptr_r, rptr_r;
  logic [1:0] count_r;
  logic       enq, deq;

  // A full FIFO still takes a write when the head leaves in the same cycle
  assign ready_o = (count_r != 2'd2) | yumi_i;
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      count_r <= 2'd0;
    end
    else
    begin
      if (enq)
        wptr_r <= ~wptr_r;
      if (deq)
        rptr_r <= ~rptr_r;
      count_r <= count_r + {1'b0, enq} - {1'b0, deq};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

  // A full FIFO keeps its count and its head until an entry leaves
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_r == 2'd2 && !deq) |=> (count_r == 2'd2 && $stable(data_o)))
    else $error("full FIFO changed without a dequeue");

  // Consumer must only take an entry that is there
  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o)
    else $error("dequeue from an empty FIFO");

endmodule

// ==== rtl/axil_mem_pkg.sv ====
`include "axil_mem_defs.svh"

package axil_mem_pkg;

  // Uncached memory message kinds
  typedef enum logic [0:0]
  {
    e_mem_uc_rd = 1'b0
    , e_mem_uc_wr = 1'b1
  } mem_msg_type_e;

  // Access size in bytes
  typedef enum logic [1:0]
  {
    e_mem_size_1 = 2'd0
    , e_mem_size_2 = 2'd1
    , e_mem_size_4 = 2'd2
  } mem_size_e;

  // AXI response codes used by this port
  typedef enum logic [1:0]
  {
    e_axil_resp_okay = 2'b00
    , e_axil_resp_slverr = 2'b10
  } axil_resp_e;

  // Command from bridge to memory, 67 bits
  typedef struct packed
  {
    mem_msg_type_e               msg_type;
    mem_size_e                   size;
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
    logic [`AXIL_DATA_WIDTH-1:0] data;
  } mem_cmd_s;

  // Response from memory to bridge, 34 bits
  typedef struct packed
  {
    mem_msg_type_e               msg_type;
    logic [`AXIL_DATA_WIDTH-1:0] data;
    logic                        err;
  } mem_resp_s;

endpackage

// ==== include/axil_mem_defs.svh ====
`ifndef AXIL_MEM_DEFS_SVH
`define AXIL_MEM_DEFS_SVH

// AXI4-Lite address width
`define AXIL_ADDR_WIDTH 32

// AXI4-Lite data width, also the scratchpad word width
`define AXIL_DATA_WIDTH 32

// One strobe bit per data byte
`define AXIL_STRB_WIDTH 4

// Scratchpad depth in words
// Address bits 7:2 pick the word, anything above bit 7 is out of range
`define SCRATCH_WORDS 64

`endif
